/* crypto_host_settings.svh */
/* Round count may be set from 1 to 31, since the round index is 5 bits wide.
   The key pattern sits in bits 127:96 of the round key word before the shift */
`ifndef CRYPTO_HOST_SETTINGS_SVH
`define CRYPTO_HOST_SETTINGS_SVH

// Rounds per block
`define CH_ROUNDS 16

// Seed word for the round keys
// Shifted right by the round index, then XORed with the captured key
`define CH_KEY_PATTERN 32'h89ABCDEF

// Latency from the start edge to the done edge is 3 * CH_ROUNDS + 2 cycles
// One load edge, three edges per round, the last add_key check and the final edge

`endif

/* crypto_host_pkg.sv */
/* Types shared by the cipher engine. Blocks are fixed at 128 bits
   and the round index is 5 bits, so at most 31 rounds */
package crypto_host_pkg;

    typedef logic [127:0] block_t;  // Plaintext, key, state and ciphertext
    typedef logic [7:0]   byte_t;   // S-box input and output
    typedef logic [4:0]   round_t;  // Round index

    // Mixing step applied at the end of every round
    typedef enum logic [1:0] {
        mode_fold   = 2'd0,  // State XOR upper half moved down
        mode_rotate = 2'd1,  // Rotate left by one bit
        mode_add    = 2'd2,  // Add round index plus one
        mode_invert = 2'd3   // Bitwise inversion
    } crypto_mode_t;

    typedef enum logic [2:0] {
        st_idle,
        st_add_key,
        st_sub_bytes,
        st_mix,
        st_final
    } fsm_state_t;

    // Datapath strobes, at most one high per cycle
    typedef struct packed {
        logic load;
        logic add_key;
        logic sub_bytes;
        logic mix;
        logic finish;
    } round_ctrl_t;

endpackage

/* round_counter.sv */
/* Counts completed rounds. Clear has priority over step
   and last is high once the count reaches CH_ROUNDS */
`timescale 1ns/10ps
`include "crypto_host_settings.svh"

module round_counter (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    clear,
    input  logic                    step,
    output crypto_host_pkg::round_t round,
    output logic                    last
);
    import crypto_host_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            round <= '0;
        end else if (clear) begin
            round <= '0;  // New block starts at round 0
        end else if (step) begin
            round <= round + round_t'(1);
        end
    end

    // All rounds done, FSM goes to the final key addition
    assign last = (round == round_t'(`CH_ROUNDS));

endmodule

/* key_schedule.sv */
/* Round keys are derived on the fly from the key captured at start.
   Both outputs are combinational in the captured key and the round index */
`timescale 1ns/10ps
`include "crypto_host_settings.svh"

module key_schedule (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    capture,
    input  crypto_host_pkg::block_t key,
    input  crypto_host_pkg::round_t round,
    output crypto_host_pkg::block_t round_key,
    output crypto_host_pkg::block_t first_key
);
    import crypto_host_pkg::*;

    // Pattern placed in the top word
    localparam block_t pattern_word = {`CH_KEY_PATTERN, 96'h0};

    block_t key_q;

    // Hold the key for the whole block so the input may change while busy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_q <= '0;
        end else if (capture) begin
            key_q <= key;
        end
    end

    // Pattern walks right by one bit per round
    assign round_key = key_q ^ (pattern_word >> round);

    assign first_key = key_q ^ pattern_word;  // Round 0 key, used by the final step

endmodule

/* round_fsm.sv */
/* Sequences load, key addition, substitution and mixing for each round.
   Start is only sampled in st_idle; done is a registered one-cycle pulse */
`timescale 1ns/10ps

module round_fsm (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         encrypt_start,
    input  logic                         last,
    output crypto_host_pkg::round_ctrl_t ctrl,
    output logic                         clear,
    output logic                         step,
    output logic                         capture,
    output logic                         busy,
    output logic                         encrypt_done
);
    import crypto_host_pkg::*;

    fsm_state_t state;
    fsm_state_t next_state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= st_idle;
            encrypt_done <= 1'b0;
        end else begin
            state        <= next_state;
            encrypt_done <= ctrl.finish;  // Rises with the ciphertext write
        end
    end

    always_comb begin
        next_state = state;
        ctrl       = '0;
        clear      = 1'b0;
        step       = 1'b0;
        capture    = 1'b0;
        case (state)
            st_idle: begin
                if (encrypt_start) begin
                    ctrl.load  = 1'b1;  // Load happens on the sampling edge
                    clear      = 1'b1;
                    capture    = 1'b1;
                    next_state = st_add_key;
                end
            end
            st_add_key: begin
                // After the last round this is only a check, state is untouched
                if (last) begin
                    next_state = st_final;
                end else begin
                    ctrl.add_key = 1'b1;
                    next_state   = st_sub_bytes;
                end
            end
            st_sub_bytes: begin
                ctrl.sub_bytes = 1'b1;
                next_state     = st_mix;
            end
            st_mix: begin
                ctrl.mix   = 1'b1;
                step       = 1'b1;  // Round count moves with the mix edge
                next_state = st_add_key;
            end
            st_final: begin
                ctrl.finish = 1'b1;
                next_state  = st_idle;
            end
            default: next_state = st_idle;
        endcase
    end

    // Falls on the same edge that raises done
    assign busy = (state != st_idle);

endmodule

/* round_datapath.sv */
/* State register, 4-bit S-box on the low byte and the mode mixing step.
   Mode is captured on load, so the mode input may change during a block */
`timescale 1ns/10ps

module round_datapath (
    input  logic                          clk,
    input  logic                          rst,
    input  crypto_host_pkg::round_ctrl_t  ctrl,
    input  crypto_host_pkg::block_t       plaintext,
    input  crypto_host_pkg::crypto_mode_t crypto_mode,
    input  crypto_host_pkg::round_t       round,
    input  crypto_host_pkg::block_t       round_key,
    input  crypto_host_pkg::block_t       first_key,
    output crypto_host_pkg::block_t       ciphertext
);
    import crypto_host_pkg::*;

    block_t       state_q;
    crypto_mode_t mode_q;
    byte_t        sbox_in;
    byte_t        sbox_base;
    byte_t        sbox_out;
    block_t       mixed;

    assign sbox_in = state_q[7:0];

    // Table on the low nibble
    always_comb begin
        case (sbox_in[3:0])
            4'h0: sbox_base = 8'h63;
            4'h1: sbox_base = 8'h7C;
            4'h2: sbox_base = 8'h77;
            4'h3: sbox_base = 8'h7B;
            4'h4: sbox_base = 8'hF2;
            4'h5: sbox_base = 8'h6B;
            4'h6: sbox_base = 8'h6F;
            4'h7: sbox_base = 8'hC5;
            4'h8: sbox_base = 8'h30;
            4'h9: sbox_base = 8'h01;
            4'hA: sbox_base = 8'h67;
            4'hB: sbox_base = 8'h2B;
            4'hC: sbox_base = 8'hFE;
            4'hD: sbox_base = 8'hD7;
            4'hE: sbox_base = 8'hAB;
            4'hF: sbox_base = 8'h76;
            default: sbox_base = 8'h63;
        endcase
    end

    assign sbox_out = sbox_base ^ {4'h0, sbox_in[7:4]};  // High nibble folded in

    // Round index here is still the current round, step lands on this edge
    always_comb begin
        case (mode_q)
            mode_fold:   mixed = state_q ^ (state_q >> 64);
            mode_rotate: mixed = {state_q[126:0], state_q[127]};
            mode_add:    mixed = state_q + block_t'(round) + block_t'(1);
            mode_invert: mixed = ~state_q;
            default:     mixed = state_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.load) begin
            state_q <= plaintext;
        end else if (ctrl.add_key) begin
            state_q <= state_q ^ round_key;
        end else if (ctrl.sub_bytes) begin
            state_q <= {state_q[119:0], sbox_out};  // Shift left one byte
        end else if (ctrl.mix) begin
            state_q <= mixed;
        end
    end

    // Ciphertext holds until the next finish
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode_q     <= mode_fold;
            ciphertext <= '0;
        end else begin
            if (ctrl.load) begin
                mode_q <= crypto_mode;
            end
            if (ctrl.finish) begin
                ciphertext <= state_q ^ first_key;
            end
        end
    end

endmodule

/* crypto_host.sv */
/* Round-based 128-bit block cipher engine with a plain start strobe and done pulse.
   Done follows start by 3 * CH_ROUNDS + 2 cycles; start is ignored while busy */
`timescale 1ns/10ps

module crypto_host (
    input  logic                          clk,
    input  logic                          rst,
    input  crypto_host_pkg::block_t       plaintext,
    input  crypto_host_pkg::block_t       key,
    input  crypto_host_pkg::crypto_mode_t crypto_mode,
    input  logic                          encrypt_start,
    output crypto_host_pkg::block_t       ciphertext,
    output logic                          encrypt_done,
    output logic                          busy
);
    import crypto_host_pkg::*;

    round_ctrl_t ctrl;
    logic        clear;
    logic        step;
    logic        capture;
    logic        last;
    round_t      round;
    block_t      round_key;
    block_t      first_key;

    round_fsm i_fsm (
        .clk           (clk),
        .rst           (rst),
        .encrypt_start (encrypt_start),
        .last          (last),
        .ctrl          (ctrl),
        .clear         (clear),
        .step          (step),
        .capture       (capture),
        .busy          (busy),
        .encrypt_done  (encrypt_done)
    );

    round_counter i_counter (.clk(clk), .rst(rst), .clear(clear), .step(step),
                             .round(round), .last(last));

    key_schedule i_keys (.clk(clk), .rst(rst), .capture(capture), .key(key),
                         .round(round), .round_key(round_key), .first_key(first_key));

    round_datapath i_datapath (
        .clk         (clk),
        .rst         (rst),
        .ctrl        (ctrl),
        .plaintext   (plaintext),
        .crypto_mode (crypto_mode),
        .round       (round),
        .round_key   (round_key),
        .first_key   (first_key),
        .ciphertext  (ciphertext)
    );

endmodule

/* crypto_host_chk.sv */
/* Concurrent checks on the engine's start, done and busy ports, bound into crypto_host.
   The round input is the internal counter, reached through the bind */
`timescale 1ns/10ps

module crypto_host_chk (
    input logic                    clk,
    input logic                    rst,
    input logic                    encrypt_start,
    input logic                    encrypt_done,
    input logic                    busy,
    input crypto_host_pkg::round_t round
);
    int failures = 0;

    // Done is a single-cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (rst)
        encrypt_done |=> !encrypt_done)
        else begin
            $error("encrypt_done stayed high for more than one cycle");
            failures++;
        end

    // Counter only moves forward once a block is running
    no_restart: assert property (@(posedge clk) disable iff (rst)
        (busy && encrypt_start) |=> (round >= $past(round)))
        else begin
            $error("start while busy restarted the round counter");
            failures++;
        end

    busy_ends_with_done: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) == encrypt_done)
        else begin
            $error("busy did not fall on the edge that raised encrypt_done");
            failures++;
        end

endmodule

bind crypto_host crypto_host_chk i_chk (
    .clk           (clk),
    .rst           (rst),
    .encrypt_start (encrypt_start),
    .encrypt_done  (encrypt_done),
    .busy          (busy),
    .round         (round)
);

/* tb_crypto_host.sv */
/* Directed testbench for the cipher engine. Expected ciphertext comes from a behavioral
   model of the round algorithm, random blocks from a 32-bit LFSR with a fixed seed */
`timescale 1ns/10ps
`include "crypto_host_settings.svh"

module tb_crypto_host;
    import crypto_host_pkg::*;

    localparam int run_cycles = 3 * `CH_ROUNDS + 2;  // Start edge to done edge
    localparam int max_cycles = 40 * (run_cycles + 10);
    localparam logic [127:0] sbox_row = 128'h637C777BF26B6FC53001672BFED7AB76;

    logic         clk;
    logic         rst;
    block_t       plaintext;
    block_t       key;
    crypto_mode_t crypto_mode;
    logic         encrypt_start;
    block_t       ciphertext;
    logic         encrypt_done;
    logic         busy;

    int          errors = 0;
    int          cycles = 0;
    logic [31:0] lfsr;

    crypto_host i_dut (
        .clk           (clk),
        .rst           (rst),
        .plaintext     (plaintext),
        .key           (key),
        .crypto_mode   (crypto_mode),
        .encrypt_start (encrypt_start),
        .ciphertext    (ciphertext),
        .encrypt_done  (encrypt_done),
        .busy          (busy)
    );

    always #5 clk = ~clk;

    // Run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: run did not end within %0d cycles", max_cycles);
            $display("Test failed");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_block(output block_t b);
        for (int i = 0; i < 128; i++) begin
            lfsr = lfsr_step(lfsr);  // One step per bit
            b[i] = lfsr[0];
        end
    endtask

    // Table entry 0 sits in the top byte of the row
    function automatic byte_t sbox(input byte_t x);
        int idx;
        idx = 15 - int'(x[3:0]);
        return sbox_row[idx * 8 +: 8] ^ {4'h0, x[7:4]};
    endfunction

    function automatic block_t expected_cipher(input block_t pt, input block_t k,
                                               input crypto_mode_t m);
        block_t pattern;
        block_t s;
        pattern = {`CH_KEY_PATTERN, 96'h0};
        s = pt;
        for (int r = 0; r < `CH_ROUNDS; r++) begin
            s = s ^ k ^ (pattern >> r);
            s = {s[119:0], sbox(s[7:0])};
            case (m)
                mode_fold:   s = s ^ {64'h0, s[127:64]};
                mode_rotate: s = {s[126:0], s[127]};
                mode_add:    s = s + block_t'(r + 1);
                default:     s = ~s;
            endcase
        end
        return s ^ k ^ pattern;  // Round 0 key again
    endfunction

    // Starts on a falling edge and returns on the falling edge that sees done
    task automatic run_block(input string name, input block_t pt, input block_t k,
                             input crypto_mode_t m, input int disturb_at);
        block_t exp;
        block_t held;
        int     edges;
        exp           = expected_cipher(pt, k, m);
        held          = ciphertext;
        plaintext     = pt;
        key           = k;
        crypto_mode   = m;
        encrypt_start = 1'b1;
        @(negedge clk);
        encrypt_start = 1'b0;
        edges         = 0;
        while (!encrypt_done && edges < run_cycles + 8) begin
            assert (busy) else begin
                $display("ERR %s: busy at cycle %0d expected 1, actual %b", name, edges, busy);
                errors++;
            end
            assert (ciphertext == held) else begin
                $display("ERR %s: held ciphertext expected %h, actual %h",
                         name, held, ciphertext);
                errors++;
            end
            if (edges == disturb_at) begin
                encrypt_start = 1'b1;  // Lands while busy
                plaintext     = ~pt;
                key           = ~k;
                crypto_mode   = crypto_mode_t'(~m);
            end
            @(negedge clk);
            encrypt_start = 1'b0;
            edges++;
        end
        if (!encrypt_done) begin
            $display("%s: no done pulse within %0d cycles of start", name, edges);
            errors++;
        end else begin
            assert (edges == run_cycles) else begin
                $display("ERR %s: latency expected %0d, actual %0d", name, run_cycles, edges);
                errors++;
            end
            assert (!busy) else begin
                $display("ERR %s: busy at done expected 0, actual %b", name, busy);
                errors++;
            end
            assert (ciphertext == exp) else begin
                $display("ERR %s: ciphertext expected %h, actual %h", name, exp, ciphertext);
                errors++;
            end
        end
    endtask

    task automatic check_reset();
        assert (!encrypt_done && !busy) else begin
            $display("ERR reset: done busy expected 0 0, actual %b %b", encrypt_done, busy);
            errors++;
        end
        assert (ciphertext == '0) else begin
            $display("ERR reset: ciphertext expected %h, actual %h", 128'h0, ciphertext);
            errors++;
        end
    endtask

    task automatic check_modes();
        block_t pt;
        block_t k;
        for (int mi = 0; mi < 4; mi++) begin
            run_block("modes_fixed", 128'h00112233445566778899AABBCCDDEEFF,
                      128'h000102030405060708090A0B0C0D0E0F, crypto_mode_t'(mi[1:0]), -1);
            for (int n = 0; n < 3; n++) begin
                random_block(pt);
                random_block(k);
                @(negedge clk);  // Idle gap
                run_block("modes_random", pt, k, crypto_mode_t'(mi[1:0]), -1);
            end
            @(negedge clk);
        end
    endtask

    task automatic check_latency();
        block_t pt;
        random_block(pt);
        run_block("latency", pt, 128'hFFFF_0000_FFFF_0000_1234_5678_9ABC_DEF0, mode_add, -1);
        repeat (3) @(negedge clk);
        run_block("latency", ~pt, 128'h0, mode_rotate, -1);
        @(negedge clk);
    endtask

    // Start and new inputs early, mid run, on the last check and in the final state
    task automatic check_start_while_busy();
        block_t pt;
        block_t k;
        int     points[4];
        points = '{0, 17, run_cycles - 2, run_cycles - 1};
        for (int i = 0; i < 4; i++) begin
            random_block(pt);
            random_block(k);
            run_block("start_while_busy", pt, k, crypto_mode_t'(i[1:0]), points[i]);
            repeat (2) @(negedge clk);
        end
    endtask

    task automatic check_back_to_back();
        block_t pt;
        block_t k;
        block_t last_ct;
        for (int i = 0; i < 6; i++) begin
            random_block(pt);
            random_block(k);
            run_block("back_to_back", pt, k, crypto_mode_t'(i[1:0]), -1);
        end
        last_ct = ciphertext;
        random_block(pt);
        random_block(k);
        plaintext   = pt;  // New inputs without a start
        key         = k;
        crypto_mode = mode_invert;
        repeat (5) @(negedge clk);
        assert (ciphertext == last_ct) else begin
            $display("ERR back_to_back: idle ciphertext expected %h, actual %h",
                     last_ct, ciphertext);
            errors++;
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst           = 1'b1;
        plaintext     = '0;
        key           = '0;
        crypto_mode   = mode_fold;
        encrypt_start = 1'b0;
        lfsr          = 32'h4256;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_reset();
        check_modes();
        check_latency();
        check_start_while_busy();
        check_back_to_back();
        $display("Checks done: %0d errors, %0d assertion failures",
                 errors, i_dut.i_chk.failures);
        if (errors == 0 && i_dut.i_chk.failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* crypto_host.f */
+incdir+.
crypto_host_pkg.sv
round_counter.sv
key_schedule.sv
round_fsm.sv
round_datapath.sv
crypto_host.sv
crypto_host_chk.sv
tb_crypto_host.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and passes only on the pass message
cd "$(dirname "$0")" &&
    verilator --binary --assert --timing --top-module tb_crypto_host \
        -f crypto_host.f -o sim_crypto_host &&
    ./obj_dir/sim_crypto_host | tee /dev/stderr | grep "Test passed" > /dev/null &&
    echo "PASS" ||
    { echo "FAIL"; exit 1; }
